/* Makefile */
# Verilator build and run for the card core testbench

VERILATOR ?= verilator
TOP       ?= a2card_tb
FILELIST  ?= a2card_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

SOURCES := $(wildcard rtl/*.sv testbench/*.sv testbench/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* a2card_core.f */
+incdir+testbench
rtl/a2card_pkg.sv
rtl/bus_response.sv
rtl/audio_mixer.sv
rtl/scanline_dimmer.sv
rtl/panel_control.sv
rtl/a2card_core.sv
testbench/a2card_tb.sv

/* rtl/a2card_core.sv */
// Apple II card glue core

`timescale 1ns/1ps
`default_nettype none

module a2card_core #(
    parameter int DEBOUNCE_CYCLES = a2card_pkg::DEBOUNCE_CYCLES_DEF
) (
    input  logic                                              clk_logic_w,
    input  logic                                              rst_n_i,

    // Slot bus
    input  a2card_pkg::slot_resp_t [a2card_pkg::NUM_SRC-1:0] resp_i,
    input  a2card_pkg::byte_t                                 bus_data_i,

    input  a2card_pkg::audio_src_t                            audio_src_i,

    // Video
    input  a2card_pkg::rgb_t                                  pixel_i,
    input  a2card_pkg::coord_t                                y_i,
    input  logic                                              dim_en_i,

    // Front panel
    input  logic                                              button_i,
    input  a2card_pkg::mode_flags_t                           mode_i,

    output logic                                              data_out_en_o,
    output a2card_pkg::byte_t                                 data_out_o,
    output logic                                              irq_n_o,
    output a2card_pkg::sample_t                               audio_l_o,
    output a2card_pkg::sample_t                               audio_r_o,
    output a2card_pkg::rgb_t                                  pixel_o,
    output logic                                              overlay_en_o,
    output logic [4:0]                                        led_o
);

    bus_response u_bus_response (
        .clk_logic_w   (clk_logic_w),
        .rst_n_i       (rst_n_i),
        .resp_i        (resp_i),
        .bus_data_i    (bus_data_i),
        .data_out_en_o (data_out_en_o),
        .data_out_o    (data_out_o),
        .irq_n_o       (irq_n_o)
    );

    audio_mixer u_audio_mixer (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .src_i       (audio_src_i),
        .audio_l_o   (audio_l_o),
        .audio_r_o   (audio_r_o)
    );

    scanline_dimmer u_scanline_dimmer (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .pixel_i     (pixel_i),
        .y_i         (y_i),
        .dim_en_i    (dim_en_i),
        .pixel_o     (pixel_o)
    );

    panel_control #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_panel_control (
        .clk_logic_w  (clk_logic_w),
        .rst_n_i      (rst_n_i),
        .button_i     (button_i),
        .mode_i       (mode_i),
        .overlay_en_o (overlay_en_o),
        .led_o        (led_o)
    );

endmodule

`default_nettype wire

/* rtl/a2card_pkg.sv */
// Apple II card core
// Shared widths, types and constants

`default_nettype none

package a2card_pkg;

    typedef logic [7:0] byte_t;           // Apple bus data
    typedef logic [9:0] level_t;          // Unsigned audio level
    typedef logic signed [15:0] sample_t; // GLU output and final mix
    typedef logic [7:0] color_t;
    typedef logic [9:0] coord_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    // One peripheral's bus response
    typedef struct packed {
        logic  rd_en;
        byte_t data;
        logic  irq_n; // Tied high when the card has no interrupt
    } slot_resp_t;

    typedef struct packed {
        logic    speaker;
        level_t  sprite;
        level_t  mb_l;
        level_t  mb_r;
        sample_t glu_l;
        sample_t glu_r;
    } audio_src_t;

    // LED order, MSB first
    typedef struct packed {
        logic text;
        logic shrg;
        logic hires;
        logic ramwrt;
        logic store80;
    } mode_flags_t;

    // Read sources, lower index wins
    localparam int SRC_SERIAL  = 0;
    localparam int SRC_SPRITE  = 1;
    localparam int SRC_MOCKING = 2;
    localparam int SRC_DISK    = 3;
    localparam int SRC_CARDROM = 4;
    localparam int NUM_SRC     = 5;

    // Only these cards can raise an interrupt
    localparam logic [NUM_SRC-1:0] IRQ_SRC_MASK =
        NUM_SRC'((1 << SRC_SERIAL) | (1 << SRC_SPRITE) | (1 << SRC_MOCKING));

    localparam int DEBOUNCE_CYCLES_DEF = 540_000; // 10 ms at 54 MHz

    localparam int SPEAKER_SHIFT = 12; // Speaker sits at the top of 13 bits
    localparam int LEVEL_SHIFT   = 3;
    localparam int DIM_SHIFT     = 1;

endpackage

`default_nettype wire

/* rtl/audio_mixer.sv */
// Audio source mixer

`timescale 1ns/1ps
`default_nettype none

module audio_mixer (
    input  logic                   clk_logic_w,
    input  logic                   rst_n_i,
    input  a2card_pkg::audio_src_t src_i,
    output a2card_pkg::sample_t    audio_l_o,
    output a2card_pkg::sample_t    audio_r_o
);

    // Unsigned sources widened to 13 bits
    logic [a2card_pkg::SPEAKER_SHIFT:0] speaker_ext;
    logic [a2card_pkg::SPEAKER_SHIFT:0] sprite_ext;
    logic [a2card_pkg::SPEAKER_SHIFT:0] mb_l_ext;
    logic [a2card_pkg::SPEAKER_SHIFT:0] mb_r_ext;

    logic [15:0] mix_l;
    logic [15:0] mix_r;

    assign speaker_ext = {src_i.speaker, {a2card_pkg::SPEAKER_SHIFT{1'b0}}};
    assign sprite_ext  = {src_i.sprite, {a2card_pkg::LEVEL_SHIFT{1'b0}}};
    assign mb_l_ext    = {src_i.mb_l, {a2card_pkg::LEVEL_SHIFT{1'b0}}};
    assign mb_r_ext    = {src_i.mb_r, {a2card_pkg::LEVEL_SHIFT{1'b0}}};

    // Modulo 2^16, no clipping
    assign mix_l = src_i.glu_l + 16'(sprite_ext) + 16'(mb_l_ext) + 16'(speaker_ext);
    assign mix_r = src_i.glu_r + 16'(sprite_ext) + 16'(mb_r_ext) + 16'(speaker_ext);

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            audio_l_o <= '0;
            audio_r_o <= '0;
        end else begin
            audio_l_o <= a2card_pkg::sample_t'(mix_l);
            audio_r_o <= a2card_pkg::sample_t'(mix_r);
        end
    end

endmodule

`default_nettype wire

/* rtl/bus_response.sv */
// Slot read response and interrupt merge

`timescale 1ns/1ps
`default_nettype none

module bus_response (
    input  logic                                              clk_logic_w,
    input  logic                                              rst_n_i,
    input  a2card_pkg::slot_resp_t [a2card_pkg::NUM_SRC-1:0] resp_i,
    input  a2card_pkg::byte_t                                 bus_data_i,
    output logic                                              data_out_en_o,
    output a2card_pkg::byte_t                                 data_out_o,
    output logic                                              irq_n_o
);

    logic              sel_en;
    a2card_pkg::byte_t sel_data;
    logic              irq_all_n;

    // Walk from lowest priority up so the lowest index is applied last
    always_comb begin
        sel_en    = 1'b0;
        sel_data  = bus_data_i; // Pass-through when nobody reads
        irq_all_n = 1'b1;
        for (int i = a2card_pkg::NUM_SRC - 1; i >= 0; i--) begin
            if (resp_i[i].rd_en) begin
                sel_en   = 1'b1;
                sel_data = resp_i[i].data;
            end
            if (a2card_pkg::IRQ_SRC_MASK[i] && !resp_i[i].irq_n) begin
                irq_all_n = 1'b0; // Wired-AND of active-low lines
            end
        end
    end

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_out_en_o <= 1'b0;
            irq_n_o       <= 1'b1;
        end else begin
            data_out_en_o <= sel_en;
            irq_n_o       <= irq_all_n;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        data_out_o <= sel_data;
    end

endmodule

`default_nettype wire

/* rtl/panel_control.sv */
// Front panel button and mode LEDs

`timescale 1ns/1ps
`default_nettype none

module panel_control #(
    parameter int DEBOUNCE_CYCLES = a2card_pkg::DEBOUNCE_CYCLES_DEF
) (
    input  logic                    clk_logic_w,
    input  logic                    rst_n_i,
    input  logic                    button_i,
    input  a2card_pkg::mode_flags_t mode_i,
    output logic                    overlay_en_o,
    output logic [4:0]              led_o
);

    typedef logic [$clog2(DEBOUNCE_CYCLES + 1)-1:0] cnt_t;

    logic [1:0] btn_sync; // Two-flop synchroniser, [1] is the stable copy
    logic       btn_db;   // Debounced level
    cnt_t       db_cnt;

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            btn_sync <= 2'b00;
        end else begin
            btn_sync <= {btn_sync[0], button_i};
        end
    end

    // Level only follows after DEBOUNCE_CYCLES differing cycles in a row
    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            btn_db       <= 1'b0;
            db_cnt       <= '0;
            overlay_en_o <= 1'b0;
        end else if (btn_sync[1] != btn_db) begin
            if (db_cnt == cnt_t'(DEBOUNCE_CYCLES - 1)) begin
                btn_db <= btn_sync[1];
                db_cnt <= '0;
                if (btn_sync[1]) begin
                    overlay_en_o <= ~overlay_en_o; // Press edge
                end
            end else begin
                db_cnt <= db_cnt + 1'b1;
            end
        end else begin
            db_cnt <= '0; // Bounce restarts the count
        end
    end

    // LEDs are active low
    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) led_o <= '1;
        else          led_o <= ~mode_i;
    end

endmodule

`default_nettype wire

/* rtl/scanline_dimmer.sv */
// Scanline dimming

`timescale 1ns/1ps
`default_nettype none

module scanline_dimmer (
    input  logic               clk_logic_w,
    input  logic               rst_n_i,
    input  a2card_pkg::rgb_t   pixel_i,
    input  a2card_pkg::coord_t y_i,
    input  logic               dim_en_i,
    output a2card_pkg::rgb_t   pixel_o
);

    logic             dim_line;
    a2card_pkg::rgb_t pixel_d;

    function automatic a2card_pkg::color_t dim_channel(input a2card_pkg::color_t c,
                                                       input logic dim);
        return dim ? (c >> a2card_pkg::DIM_SHIFT) : c;
    endfunction

    assign dim_line = dim_en_i & y_i[0]; // Odd lines only

    always_comb begin
        pixel_d.r = dim_channel(pixel_i.r, dim_line);
        pixel_d.g = dim_channel(pixel_i.g, dim_line);
        pixel_d.b = dim_channel(pixel_i.b, dim_line);
    end

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) pixel_o <= '0;
        else          pixel_o <= pixel_d;
    end

endmodule

`default_nettype wire

/* testbench/a2card_ref.svh */
// Reference model for the card core
`ifndef A2CARD_REF_SVH
`define A2CARD_REF_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x ^ (x << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
endfunction

// Gives {enable, byte} of the first reader in priority order
function automatic logic [8:0] read_response(
    input a2card_pkg::slot_resp_t [a2card_pkg::NUM_SRC-1:0] resp,
    input a2card_pkg::byte_t                                 bus_data
);
    logic [8:0] r;
    r = {1'b0, bus_data};
    for (int i = 0; i < a2card_pkg::NUM_SRC; i++) begin
        if (resp[i].rd_en && !r[8]) r = {1'b1, resp[i].data};
    end
    return r;
endfunction

// Disk II and card ROM never interrupt
function automatic logic merged_irq_n(
    input a2card_pkg::slot_resp_t [a2card_pkg::NUM_SRC-1:0] resp
);
    return resp[a2card_pkg::SRC_SERIAL].irq_n & resp[a2card_pkg::SRC_SPRITE].irq_n
         & resp[a2card_pkg::SRC_MOCKING].irq_n;
endfunction

function automatic a2card_pkg::sample_t mixed_sample(input a2card_pkg::sample_t glu,
                                                     input a2card_pkg::level_t  sprite,
                                                     input a2card_pkg::level_t  mb,
                                                     input logic                speaker);
    int sum;
    sum = int'(glu) + int'(sprite) * 8 + int'(mb) * 8 + (speaker ? 4096 : 0);
    return sum[15:0]; // Wraps modulo 2^16
endfunction

function automatic a2card_pkg::rgb_t dimmed_pixel(input a2card_pkg::rgb_t   pixel,
                                                  input a2card_pkg::coord_t y,
                                                  input logic               dim_en);
    a2card_pkg::rgb_t d;
    d = pixel;
    if (dim_en && y[0]) begin
        d.r = pixel.r / 8'd2;
        d.g = pixel.g / 8'd2;
        d.b = pixel.b / 8'd2;
    end
    return d;
endfunction

// A set flag lights its LED by pulling the pin low
function automatic logic [4:0] panel_leds(input a2card_pkg::mode_flags_t mode);
    logic [4:0] leds;
    leds = 5'b11111; // All dark
    if (mode.text)    leds[4] = 1'b0;
    if (mode.shrg)    leds[3] = 1'b0;
    if (mode.hires)   leds[2] = 1'b0;
    if (mode.ramwrt)  leds[1] = 1'b0;
    if (mode.store80) leds[0] = 1'b0;
    return leds;
endfunction

`endif

/* testbench/a2card_tb.sv */
// Testbench for the card core

`timescale 1ns/1ps
`default_nettype none

module a2card_tb;

    `include "a2card_ref.svh"

    typedef struct packed {
        a2card_pkg::slot_resp_t [a2card_pkg::NUM_SRC-1:0] resp;
        a2card_pkg::byte_t       bus_data;
        a2card_pkg::audio_src_t  audio;
        a2card_pkg::rgb_t        pixel;
        a2card_pkg::coord_t      y;
        logic                    dim_en;
        logic                    button;
        a2card_pkg::mode_flags_t mode;
    } stim_t;

    typedef struct packed {
        logic                en;
        a2card_pkg::byte_t   data;
        logic                irq_n;
        a2card_pkg::sample_t audio_l;
        a2card_pkg::sample_t audio_r;
        a2card_pkg::rgb_t    pixel;
        logic [4:0]          led;
    } expect_t;

    logic clk_logic_w;
    logic rst_n_i;

    a2card_pkg::slot_resp_t [a2card_pkg::NUM_SRC-1:0] resp;
    a2card_pkg::byte_t       bus_data;
    a2card_pkg::audio_src_t  audio_src;
    a2card_pkg::rgb_t        pixel_in;
    a2card_pkg::coord_t      y;
    logic                    dim_en;
    logic                    button;
    a2card_pkg::mode_flags_t mode;
    logic                    data_out_en;
    a2card_pkg::byte_t       data_out;
    logic                    irq_n;
    a2card_pkg::sample_t     audio_l;
    a2card_pkg::sample_t     audio_r;
    a2card_pkg::rgb_t        pixel_out;
    logic                    overlay_en;
    logic [4:0]              led;

    logic [31:0] rng = 32'h8061_4a3d;
    expect_t     exp_q[$];
    expect_t     held;
    bit          armed = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          err0;
    int          chk0;
    string       test_name;

    a2card_core #(.DEBOUNCE_CYCLES(16)) dut (
        .clk_logic_w (clk_logic_w), .rst_n_i (rst_n_i),
        .resp_i (resp), .bus_data_i (bus_data), .audio_src_i (audio_src),
        .pixel_i (pixel_in), .y_i (y), .dim_en_i (dim_en),
        .button_i (button), .mode_i (mode),
        .data_out_en_o (data_out_en), .data_out_o (data_out), .irq_n_o (irq_n),
        .audio_l_o (audio_l), .audio_r_o (audio_r), .pixel_o (pixel_out),
        .overlay_en_o (overlay_en), .led_o (led)
    );

    initial begin
        clk_logic_w = 1'b0;
        forever #4 clk_logic_w = ~clk_logic_w;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    function automatic expect_t expected_of(input stim_t s);
        expect_t    e;
        logic [8:0] rd;
        rd        = read_response(s.resp, s.bus_data);
        e.en      = rd[8];
        e.data    = rd[7:0];
        e.irq_n   = merged_irq_n(s.resp);
        e.audio_l = mixed_sample(s.audio.glu_l, s.audio.sprite, s.audio.mb_l, s.audio.speaker);
        e.audio_r = mixed_sample(s.audio.glu_r, s.audio.sprite, s.audio.mb_r, s.audio.speaker);
        e.pixel   = dimmed_pixel(s.pixel, s.y, s.dim_en);
        e.led     = panel_leds(s.mode);
        return e;
    endfunction

    task automatic compare_outputs(input expect_t e);
        check_value("data_out_en_o", 32'(data_out_en), 32'(e.en));
        check_value("data_out_o", 32'(data_out), 32'(e.data));
        check_value("irq_n_o", 32'(irq_n), 32'(e.irq_n));
        check_value("audio_l_o", {16'h0, audio_l}, {16'h0, e.audio_l});
        check_value("audio_r_o", {16'h0, audio_r}, {16'h0, e.audio_r});
        check_value("pixel_o", 32'(pixel_out), 32'(e.pixel));
        check_value("led_o", 32'(led), 32'(e.led));
    endtask

    // Outputs seen here belong to the stimulus taken one edge earlier
    always @(posedge clk_logic_w) begin
        if (armed) compare_outputs(held);
        armed = (exp_q.size() > 0);
        if (armed) held = exp_q.pop_front();
    end

    task automatic random_stim(output stim_t s);
        for (int i = 0; i < a2card_pkg::NUM_SRC; i++) begin
            rng = xorshift32(rng);
            s.resp[i].rd_en = rng[0];
            s.resp[i].data  = rng[15:8];
            s.resp[i].irq_n = rng[16];
        end
        rng = xorshift32(rng);
        s.audio.glu_l = rng[15:0];
        s.audio.glu_r = rng[31:16];
        rng = xorshift32(rng);
        s.audio.sprite  = rng[9:0];
        s.audio.mb_l    = rng[19:10];
        s.audio.mb_r    = rng[29:20];
        s.audio.speaker = rng[30];
        rng = xorshift32(rng);
        s.pixel  = rng[23:0];
        s.bus_data = rng[31:24];
        rng = xorshift32(rng);
        s.y      = rng[9:0];
        s.dim_en = rng[10];
        s.mode   = rng[15:11];
        s.button = 1'b0;
    endtask

    // Drive on the falling edge and queue the expected outputs
    task automatic apply_cycle(input stim_t s);
        @(negedge clk_logic_w);
        resp      = s.resp;
        bus_data  = s.bus_data;
        audio_src = s.audio;
        pixel_in  = s.pixel;
        y         = s.y;
        dim_en    = s.dim_en;
        button    = s.button;
        mode      = s.mode;
        exp_q.push_back(expected_of(s));
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err0      = errors;
        chk0      = checks;
        tests++;
    endtask

    task automatic end_test();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || armed) && n < 10) begin
            @(negedge clk_logic_w);
            n++;
        end
        if (exp_q.size() != 0 || armed) begin
            $display("Timeout: queued output checks did not complete in %s", test_name);
            errors++;
        end
        $display("test %-10s %0d checks, %0d failures", test_name, checks - chk0,
                 errors - err0);
    endtask

    task automatic hold_button(input logic level, input int cycles);
        stim_t s;
        for (int n = 0; n < cycles; n++) begin
            random_stim(s);
            s.button = level;
            apply_cycle(s);
        end
    endtask

    task automatic press_until(input logic want);
        int n;
        n = 0;
        while (overlay_en !== want && n < 64) begin
            hold_button(1'b1, 1);
            n++;
        end
        if (overlay_en !== want) begin
            $display("Timeout: overlay enable did not toggle after a button press");
            errors++;
        end
        hold_button(1'b1, 24); // Well past the debounce count
        hold_button(1'b0, 40);
        check_value("overlay_en_o", 32'(overlay_en), 32'(want));
    endtask

    initial begin
        stim_t s;
        logic  ov;
        rst_n_i   = 1'b0;
        resp      = '0;
        bus_data  = '0;
        audio_src = '0;
        pixel_in  = '0;
        y         = '0;
        dim_en    = 1'b0;
        button    = 1'b0;
        mode      = '0;

        begin_test("reset");
        repeat (8) @(negedge clk_logic_w);
        rst_n_i = 1'b1; // Reset values still showing until the next rising edge
        check_value("data_out_en_o", 32'(data_out_en), 32'h0);
        check_value("irq_n_o", 32'(irq_n), 32'h1);
        check_value("audio_l_o", {16'h0, audio_l}, 32'h0);
        check_value("audio_r_o", {16'h0, audio_r}, 32'h0);
        check_value("pixel_o", 32'(pixel_out), 32'h0);
        check_value("overlay_en_o", 32'(overlay_en), 32'h0);
        check_value("led_o", 32'(led), 32'h1f);
        end_test();

        begin_test("read");
        for (int n = 0; n < 200; n++) begin
            random_stim(s);
            if (n % 8 == 0) begin
                for (int i = 0; i < a2card_pkg::NUM_SRC; i++) s.resp[i].rd_en = 1'b0;
            end
            apply_cycle(s);
        end
        end_test();

        begin_test("irq");
        random_stim(s);
        for (int i = 0; i < a2card_pkg::NUM_SRC; i++) s.resp[i].irq_n = 1'b1;
        s.resp[a2card_pkg::SRC_DISK].irq_n    = 1'b0;
        s.resp[a2card_pkg::SRC_CARDROM].irq_n = 1'b0;
        apply_cycle(s);
        for (int n = 0; n < 100; n++) begin
            random_stim(s);
            apply_cycle(s);
        end
        end_test();

        begin_test("audio");
        s       = '0;
        s.audio.speaker = 1'b1; // Speaker alone
        apply_cycle(s);
        s.audio = {1'b1, 10'h3ff, 10'h3ff, 10'h3ff, 16'h7fff, 16'h7ff0};
        apply_cycle(s);
        s.audio = {1'b1, 10'h3ff, 10'h200, 10'h001, 16'h8000, 16'hffff};
        apply_cycle(s);
        for (int n = 0; n < 200; n++) begin
            random_stim(s);
            apply_cycle(s);
        end
        end_test();

        begin_test("dimming");
        for (int n = 0; n < 200; n++) begin
            random_stim(s);
            apply_cycle(s);
        end
        end_test();

        begin_test("panel");
        hold_button(1'b0, 50); // Random mode flags each cycle
        press_until(1'b1);
        press_until(1'b0);
        ov = overlay_en;
        hold_button(1'b1, 5); // Glitch shorter than the debounce count
        hold_button(1'b0, 40);
        check_value("overlay_en_o", 32'(overlay_en), 32'(ov));
        end_test();

        $display("Summary: %0d tests, %0d checks, %0d failures", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
